/* design/lz77_pkg.sv */
/*
 * lz77 compressor shared definitions
 * sizing constants for the window, lookahead and token fields,
 * plus the controller state encoding
 */
package lz77_pkg;

  // --------------------------------------------------
  // data and window sizing
  // --------------------------------------------------
  localparam int BYTE_W   = 8;
  localparam int WIN_SIZE = 16;

  // match length limits
  localparam int LEN_MAX  = 8;
  localparam int LEN_MIN  = 3;

  // window bytes followed by lookahead bytes
  localparam int BUF_SIZE = WIN_SIZE + LEN_MAX;

  // --------------------------------------------------
  // field widths
  // --------------------------------------------------
  // holds 0..LEN_MAX
  localparam int LEN_W    = 4;
  // holds 1..WIN_SIZE
  localparam int DST_W    = 5;
  // block of 1..4095 bytes
  localparam int BLK_W    = 12;

  // controller states
  typedef enum logic [1:0] {
    CTRL_IDLE   = 2'd0,
    CTRL_FILL   = 2'd1,
    CTRL_SEARCH = 2'd2
  } ctrl_state_e;

endpackage

/* design/lz77_ctrl.sv */
/*
 * lz77 control sequencer
 * fetches bytes from the input FIFO, steps each match search and
 * consumes the bytes of every emitted token
 */
module lz77_ctrl (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       start_i,
  input  logic [lz77_pkg::BLK_W-1:0] cfg_len_i,
  input  logic                       any_hit_i,
  input  logic [lz77_pkg::LEN_W-1:0] tok_len_i,
  input  logic                       val_i,
  output logic                       fifo_rd_val_o,
  output logic                       shift_o,
  output logic                       pad_o,
  output logic                       search_o,
  output logic [lz77_pkg::LEN_W-1:0] step_o,
  output logic [lz77_pkg::LEN_W-1:0] look_len_o,
  output logic [lz77_pkg::DST_W-1:0] win_len_o,
  output logic                       emit_o,
  output logic                       last_o
);
  import lz77_pkg::*;

  ctrl_state_e      state_q;
  logic [BLK_W-1:0] len_q;
  logic [BLK_W-1:0] req_cnt_q;
  logic [BLK_W-1:0] cons_cnt_q;
  logic [LEN_W-1:0] adv_left_q;
  logic [LEN_W-1:0] step_q;
  logic [LEN_W-1:0] look_len_q;
  logic [DST_W-1:0] win_len_q;
  logic [DST_W:0]   win_sum;
  logic             shift_q;
  logic             pad_q;
  logic             emit_q;
  logic             issue;
  logic             issue_rd;
  logic             srch_end;

  // --------------------------------------------------
  // advance requests and search end
  // --------------------------------------------------
  // one buffer advance per cycle, a read while input remains
  assign issue    = (state_q == CTRL_FILL) && (adv_left_q != '0);
  assign issue_rd = issue && (req_cnt_q != len_q);

  // stop on a miss or at the last valid lookahead byte
  assign srch_end = (state_q == CTRL_SEARCH) &&
                    (!any_hit_i || (step_q == look_len_q - LEN_W'(1)));

  assign win_sum  = win_len_q + tok_len_i;
  assign last_o   = emit_q && (cons_cnt_q + BLK_W'(tok_len_i) == len_q);

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= CTRL_IDLE;
    end else begin
      case (state_q)
        CTRL_IDLE: begin
          if (start_i) begin
            state_q <= CTRL_FILL;
          end
        end
        CTRL_FILL: begin
          if (last_o) begin
            state_q <= CTRL_IDLE;
          end else if (!emit_q && adv_left_q == '0) begin
            state_q <= CTRL_SEARCH;
          end
        end
        CTRL_SEARCH: begin
          if (srch_end) begin
            state_q <= CTRL_FILL;
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // counters and strobes
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      len_q      <= '0;
      req_cnt_q  <= '0;
      cons_cnt_q <= '0;
      adv_left_q <= '0;
      step_q     <= '0;
      look_len_q <= '0;
      win_len_q  <= '0;
      shift_q    <= 1'b0;
      pad_q      <= 1'b0;
      emit_q     <= 1'b0;
    end else begin
      // byte or pad lands one cycle after its request
      shift_q <= issue;
      pad_q   <= issue && !issue_rd;
      emit_q  <= srch_end;
      if (state_q == CTRL_IDLE && start_i) begin
        len_q      <= cfg_len_i;
        req_cnt_q  <= '0;
        cons_cnt_q <= '0;
        look_len_q <= '0;
        win_len_q  <= '0;
        adv_left_q <= LEN_W'(LEN_MAX);
      end else begin
        if (issue) begin
          adv_left_q <= adv_left_q - LEN_W'(1);
        end
        if (issue_rd) begin
          req_cnt_q  <= req_cnt_q + BLK_W'(1);
          look_len_q <= look_len_q + LEN_W'(1);
        end
        // token known, schedule its refill
        if (emit_q) begin
          adv_left_q <= last_o ? '0 : tok_len_i;
          look_len_q <= look_len_q - tok_len_i;
          win_len_q  <= (win_sum > WIN_SIZE) ? DST_W'(WIN_SIZE) : win_sum[DST_W-1:0];
        end
        if (val_i) begin
          cons_cnt_q <= cons_cnt_q + BLK_W'(tok_len_i);
        end
      end
      if (srch_end) begin
        step_q <= '0;
      end else if (state_q == CTRL_SEARCH) begin
        step_q <= step_q + LEN_W'(1);
      end
    end
  end

  assign fifo_rd_val_o = issue_rd;
  assign shift_o       = shift_q;
  assign pad_o         = pad_q;
  assign search_o      = (state_q == CTRL_SEARCH);
  assign step_o        = step_q;
  assign look_len_o    = look_len_q;
  assign win_len_o     = win_len_q;
  assign emit_o        = emit_q;

  // reads only for block bytes still owed and lookahead room left
  a_rd_needed: assert property (@(posedge clk) disable iff (!rstn)
    fifo_rd_val_o |-> (req_cnt_q < len_q) && (look_len_q < LEN_W'(LEN_MAX)));

  a_step_max: assert property (@(posedge clk) disable iff (!rstn)
    search_o |-> (step_o <= LEN_W'(LEN_MAX - 1)));

endmodule

/* design/lz77_match.sv */
/*
 * lz77 window and comparator array
 * shift buffer of window plus lookahead, one match flag per distance,
 * lowest surviving distance reported each search step
 */
module lz77_match (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start_i,
  input  logic [lz77_pkg::BYTE_W-1:0] fifo_rd_dat_i,
  input  logic                        shift_i,
  input  logic                        pad_i,
  input  logic                        search_i,
  input  logic [lz77_pkg::LEN_W-1:0]  step_i,
  input  logic [lz77_pkg::DST_W-1:0]  win_len_i,
  output logic                        any_hit_o,
  output logic [lz77_pkg::DST_W-1:0]  hit_dst_o,
  output logic [lz77_pkg::BYTE_W-1:0] lit_byte_o
);
  import lz77_pkg::*;

  // index WIN_SIZE is the current position, lower indices are older
  logic [BYTE_W-1:0] buf_q [BUF_SIZE];
  logic [WIN_SIZE:1] flag_q;
  logic [WIN_SIZE:1] flag_base;
  logic [WIN_SIZE:1] flag_nxt;
  logic [BYTE_W-1:0] look_byte;

  // --------------------------------------------------
  // window and lookahead shift register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < BUF_SIZE; i++) begin
        buf_q[i] <= '0;
      end
    end else if (start_i) begin
      for (int i = 0; i < BUF_SIZE; i++) begin
        buf_q[i] <= '0;
      end
    end else if (shift_i) begin
      for (int i = 0; i < BUF_SIZE - 1; i++) begin
        buf_q[i] <= buf_q[i + 1];
      end
      // pad fills the tail once the block input is used up
      buf_q[BUF_SIZE - 1] <= pad_i ? '0 : fifo_rd_dat_i;
    end
  end

  // --------------------------------------------------
  // per-distance comparators
  // --------------------------------------------------
  always_comb begin
    look_byte = buf_q[WIN_SIZE + int'(step_i)];
    for (int d = 1; d <= WIN_SIZE; d++) begin
      // step 0 opens every distance inside the filled window
      flag_base[d] = (step_i == '0) ? (d <= int'(win_len_i)) : flag_q[d];
      // source may run into the lookahead, which gives overlap
      flag_nxt[d]  = flag_base[d] &&
                     (buf_q[WIN_SIZE - d + int'(step_i)] == look_byte);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flag_q <= '0;
    end else if (start_i) begin
      flag_q <= '0;
    end else if (search_i) begin
      flag_q <= flag_nxt;
    end
  end

  // lowest distance wins a tie
  always_comb begin
    hit_dst_o = '0;
    for (int d = WIN_SIZE; d >= 1; d--) begin
      if (flag_nxt[d]) begin
        hit_dst_o = DST_W'(d);
      end
    end
  end

  assign any_hit_o  = search_i && (flag_nxt != '0);
  assign lit_byte_o = buf_q[WIN_SIZE];

  a_dst_in_win: assert property (@(posedge clk) disable iff (!rstn)
    any_hit_o |-> (hit_dst_o <= win_len_i));

endmodule

/* design/lz77_token.sv */
/*
 * lz77 token stage
 * keeps the best token of the running search and presents it
 * with the last and done flags of the block
 */
module lz77_token (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        search_i,
  input  logic [lz77_pkg::LEN_W-1:0]  step_i,
  input  logic                        any_hit_i,
  input  logic [lz77_pkg::DST_W-1:0]  hit_dst_i,
  input  logic [lz77_pkg::BYTE_W-1:0] lit_byte_i,
  input  logic                        emit_i,
  input  logic                        last_i,
  output logic [lz77_pkg::LEN_W-1:0]  tok_len_o,
  output logic                        val_o,
  output logic                        flg_lit_o,
  output logic [lz77_pkg::BYTE_W-1:0] dat_lit_o,
  output logic [lz77_pkg::LEN_W-1:0]  dat_len_o,
  output logic [lz77_pkg::DST_W-1:0]  dat_dst_o,
  output logic                        flg_lst_o,
  output logic                        done_o
);
  import lz77_pkg::*;

  logic              bst_lit_q;
  logic [BYTE_W-1:0] bst_byte_q;
  logic [LEN_W-1:0]  bst_len_q;
  logic [DST_W-1:0]  bst_dst_q;
  logic              val_q;
  logic              lst_q;
  logic              done_q;

  // --------------------------------------------------
  // best token so far
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bst_lit_q  <= 1'b0;
      bst_byte_q <= '0;
      bst_len_q  <= '0;
      bst_dst_q  <= '0;
    end else if (search_i) begin
      if (step_i == '0) begin
        // default to a literal of the current byte
        bst_lit_q  <= 1'b1;
        bst_byte_q <= lit_byte_i;
        bst_len_q  <= LEN_W'(1);
        bst_dst_q  <= '0;
      end else if (any_hit_i && (step_i + LEN_W'(1) >= LEN_W'(LEN_MIN))) begin
        bst_lit_q <= 1'b0;
        bst_len_q <= step_i + LEN_W'(1);
        bst_dst_q <= hit_dst_i;
      end
    end
  end

  // output strobes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_q  <= 1'b0;
      lst_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      val_q  <= emit_i;
      lst_q  <= emit_i && last_i;
      done_q <= val_q && lst_q;
    end
  end

  assign tok_len_o = bst_len_q;
  assign val_o     = val_q;
  assign flg_lit_o = val_q ? bst_lit_q : 1'b0;
  assign dat_lit_o = val_q ? bst_byte_q : '0;
  assign dat_len_o = val_q ? bst_len_q : '0;
  assign dat_dst_o = val_q ? bst_dst_q : '0;
  assign flg_lst_o = lst_q;
  assign done_o    = done_q;

  a_match_len: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && !flg_lit_o) |->
      (dat_len_o >= LEN_W'(LEN_MIN)) && (dat_len_o <= LEN_W'(LEN_MAX)));

endmodule

/* design/lz77_top.sv */
/*
 * lz77 compressor top level
 * sequencer, window matcher and token stage for one byte block
 */
module lz77_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start_i,
  input  logic [lz77_pkg::BLK_W-1:0]  cfg_len_i,
  output logic                        done_o,
  output logic                        val_o,
  output logic                        flg_lit_o,
  output logic [lz77_pkg::BYTE_W-1:0] dat_lit_o,
  output logic [lz77_pkg::LEN_W-1:0]  dat_len_o,
  output logic [lz77_pkg::DST_W-1:0]  dat_dst_o,
  output logic                        flg_lst_o,
  output logic                        fifo_rd_val_o,
  input  logic [lz77_pkg::BYTE_W-1:0] fifo_rd_dat_i
);
  import lz77_pkg::*;

  logic              shift;
  logic              pad;
  logic              search;
  logic [LEN_W-1:0]  step;
  logic [DST_W-1:0]  win_len;
  logic              emit;
  logic              last;
  logic              any_hit;
  logic [DST_W-1:0]  hit_dst;
  logic [BYTE_W-1:0] lit_byte;
  logic [LEN_W-1:0]  tok_len;

  // --------------------------------------------------
  // sequencer
  // --------------------------------------------------
  lz77_ctrl u_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .cfg_len_i     (cfg_len_i),
    .any_hit_i     (any_hit),
    .tok_len_i     (tok_len),
    .val_i         (val_o),
    .fifo_rd_val_o (fifo_rd_val_o),
    .shift_o       (shift),
    .pad_o         (pad),
    .search_o      (search),
    .step_o        (step),
    .look_len_o    (),
    .win_len_o     (win_len),
    .emit_o        (emit),
    .last_o        (last)
  );

  // window and comparators
  lz77_match u_match (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .fifo_rd_dat_i (fifo_rd_dat_i),
    .shift_i       (shift),
    .pad_i         (pad),
    .search_i      (search),
    .step_i        (step),
    .win_len_i     (win_len),
    .any_hit_o     (any_hit),
    .hit_dst_o     (hit_dst),
    .lit_byte_o    (lit_byte)
  );

  // token output
  lz77_token u_token (
    .clk        (clk),
    .rstn       (rstn),
    .search_i   (search),
    .step_i     (step),
    .any_hit_i  (any_hit),
    .hit_dst_i  (hit_dst),
    .lit_byte_i (lit_byte),
    .emit_i     (emit),
    .last_i     (last),
    .tok_len_o  (tok_len),
    .val_o      (val_o),
    .flg_lit_o  (flg_lit_o),
    .dat_lit_o  (dat_lit_o),
    .dat_len_o  (dat_len_o),
    .dat_dst_o  (dat_dst_o),
    .flg_lst_o  (flg_lst_o),
    .done_o     (done_o)
  );

endmodule

/* sim/lz77_tb.sv */
/*
 * lz77 compressor testbench
 * FIFO model, software LZ77 reference and token checks
 * over directed and random blocks
 */
module lz77_tb;
  import lz77_pkg::*;

  localparam int TOKEN_TIMEOUT = 200;
  localparam int MAX_BLK       = 4096;

  logic              clk = 1'b0;
  logic              rstn;
  logic              start_i;
  logic [BLK_W-1:0]  cfg_len_i;
  logic              done_o;
  logic              val_o;
  logic              flg_lit_o;
  logic [BYTE_W-1:0] dat_lit_o;
  logic [LEN_W-1:0]  dat_len_o;
  logic [DST_W-1:0]  dat_dst_o;
  logic              flg_lst_o;
  logic              fifo_rd_val_o;
  logic [BYTE_W-1:0] fifo_rd_dat_i;

  // current block and its expected tokens
  logic [BYTE_W-1:0] blk [MAX_BLK];
  int                blk_len = 0;
  logic              exp_lit [MAX_BLK];
  logic [BYTE_W-1:0] exp_byte [MAX_BLK];
  int                exp_len [MAX_BLK];
  int                exp_dst [MAX_BLK];
  logic              exp_lst [MAX_BLK];
  int                exp_cnt = 0;
  int                rd_idx = 0;
  int                tok_idx = 0;
  logic [BYTE_W-1:0] dec_buf [MAX_BLK];
  int                dec_len = 0;

  lz77_top dut (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .cfg_len_i     (cfg_len_i),
    .done_o        (done_o),
    .val_o         (val_o),
    .flg_lit_o     (flg_lit_o),
    .dat_lit_o     (dat_lit_o),
    .dat_len_o     (dat_len_o),
    .dat_dst_o     (dat_dst_o),
    .flg_lst_o     (flg_lst_o),
    .fifo_rd_val_o (fifo_rd_val_o),
    .fifo_rd_dat_i (fifo_rd_dat_i)
  );

  always #4 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input int got, input int exp);
    stop_run($sformatf("FAIL time %0t signal %s got 0x%0h expected 0x%0h",
                       $time, name, got, exp));
  endtask

  // --------------------------------------------------
  // FIFO model, token index and decoder
  // --------------------------------------------------
  always @(posedge clk) begin
    if (start_i) begin
      rd_idx  <= 0;
      tok_idx <= 0;
    end else begin
      // byte is valid one cycle after the read pulse
      if (fifo_rd_val_o) begin
        fifo_rd_dat_i <= blk[rd_idx];
        rd_idx        <= rd_idx + 1;
      end
      if (val_o) begin
        tok_idx <= tok_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (start_i) begin
      dec_len = 0;
    end else if (val_o && flg_lit_o) begin
      dec_buf[dec_len] = dat_lit_o;
      dec_len++;
    end else if (val_o) begin
      // byte by byte so that overlapping copies work
      for (int i = 0; i < int'(dat_len_o); i++) begin
        dec_buf[dec_len] = dec_buf[dec_len - int'(dat_dst_o)];
        dec_len++;
      end
    end
  end

  // --------------------------------------------------
  // token checks
  // --------------------------------------------------
  a_tok_count: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> (tok_idx < exp_cnt))
    else stop_run("more tokens than the reference model produced");
  a_lit_flag: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> (flg_lit_o == exp_lit[tok_idx]))
    else report_mismatch("flg_lit_o", $sampled(flg_lit_o), $sampled(exp_lit[tok_idx]));
  a_lit_byte: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && flg_lit_o) |-> (dat_lit_o == exp_byte[tok_idx]))
    else report_mismatch("dat_lit_o", $sampled(dat_lit_o), $sampled(exp_byte[tok_idx]));
  a_len: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> (dat_len_o == exp_len[tok_idx]))
    else report_mismatch("dat_len_o", $sampled(dat_len_o), $sampled(exp_len[tok_idx]));
  a_dst: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && !flg_lit_o) |-> (dat_dst_o == exp_dst[tok_idx]))
    else report_mismatch("dat_dst_o", $sampled(dat_dst_o), $sampled(exp_dst[tok_idx]));
  a_last: assert property (@(posedge clk) disable iff (!rstn)
    (val_o || flg_lst_o) |-> (val_o && flg_lst_o == exp_lst[tok_idx]))
    else report_mismatch("flg_lst_o", $sampled(flg_lst_o), $sampled(exp_lst[tok_idx]));
  a_done_next: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && flg_lst_o) |=> done_o)
    else stop_run("done_o missing one cycle after the last token");
  a_done_origin: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> $past(val_o && flg_lst_o))
    else stop_run("done_o pulsed without a last token one cycle before");
  a_idle_zero: assert property (@(posedge clk) disable iff (!rstn)
    !val_o |-> (!flg_lit_o && dat_lit_o == '0 && dat_len_o == '0 && dat_dst_o == '0))
    else stop_run("token fields not zero while val_o is low");
  a_rd_in_block: assert property (@(posedge clk) disable iff (!rstn)
    fifo_rd_val_o |-> (rd_idx < blk_len))
    else stop_run("FIFO read issued past the end of the block");

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  task automatic build_expected();
    int pos;
    int lim;
    int avail;
    int ml;
    int best_len;
    int best_dst;
    pos     = 0;
    exp_cnt = 0;
    while (pos < blk_len) begin
      best_len = 0;
      best_dst = 0;
      lim      = (blk_len - pos < LEN_MAX) ? blk_len - pos : LEN_MAX;
      avail    = (pos < WIN_SIZE) ? pos : WIN_SIZE;
      // ascending distance keeps the smallest on a tie
      for (int d = 1; d <= avail; d++) begin
        ml = 0;
        while (ml < lim && blk[pos - d + ml] == blk[pos + ml]) begin
          ml++;
        end
        if (ml > best_len) begin
          best_len = ml;
          best_dst = d;
        end
      end
      exp_lit[exp_cnt]  = (best_len < LEN_MIN);
      exp_byte[exp_cnt] = blk[pos];
      exp_len[exp_cnt]  = (best_len < LEN_MIN) ? 1 : best_len;
      exp_dst[exp_cnt]  = (best_len < LEN_MIN) ? 0 : best_dst;
      pos               = pos + exp_len[exp_cnt];
      exp_lst[exp_cnt]  = (pos == blk_len);
      exp_cnt++;
    end
  endtask

  task automatic append_byte(input logic [BYTE_W-1:0] b);
    blk[blk_len] = b;
    blk_len++;
  endtask

  task automatic wait_for_val();
    int cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
      if (cyc > TOKEN_TIMEOUT) stop_run("timeout waiting for a token on val_o");
    end while (!val_o);
  endtask

  task automatic wait_for_done();
    int cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
      if (cyc > TOKEN_TIMEOUT) stop_run("timeout waiting for done_o");
    end while (!done_o);
  endtask

  task automatic run_block();
    build_expected();
    @(posedge clk);
    start_i   <= 1'b1;
    cfg_len_i <= BLK_W'(blk_len);
    @(posedge clk);
    start_i <= 1'b0;
    for (int t = 0; t < exp_cnt; t++) begin
      wait_for_val();
    end
    wait_for_done();
    // whole block read once and rebuilt by the decoder
    assert (rd_idx == blk_len) else report_mismatch("fifo_rd_val_o count", rd_idx, blk_len);
    assert (tok_idx == exp_cnt) else report_mismatch("val_o count", tok_idx, exp_cnt);
    assert (dec_len == blk_len) else report_mismatch("decoded length", dec_len, blk_len);
    for (int i = 0; i < blk_len; i++) begin
      assert (dec_buf[i] === blk[i]) else report_mismatch("decoded byte", dec_buf[i], blk[i]);
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    int rnd_len [3];
    rnd_len       = '{1, 2, 300};
    rstn          = 1'b0;
    start_i       = 1'b0;
    cfg_len_i     = '0;
    fifo_rd_dat_i = '0;
    void'($urandom(32'hfd3e));
    repeat (10) @(posedge clk);
    rstn <= 1'b1;

    // distinct bytes, literals only
    blk_len = 0;
    for (int i = 0; i < 20; i++) append_byte(8'(8'h11 + 7 * i));
    run_block();

    // 4-byte pattern three times, then 9-byte pattern twice
    blk_len = 0;
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 4; i++) append_byte(8'(8'ha0 + i));
    end
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 9; i++) append_byte(8'(8'h30 + i));
    end
    run_block();

    // single byte run, overlapping distance 1 copies
    blk_len = 0;
    for (int i = 0; i < 25; i++) append_byte(8'h5a);
    run_block();

    // random blocks over a small alphabet so matches occur
    for (int b = 0; b < 3; b++) begin
      blk_len = 0;
      for (int i = 0; i < rnd_len[b]; i++) append_byte(8'($urandom % 4));
      run_block();
    end

    $display("No errors");
    $finish;
  end

endmodule

/* lz77_comp.f */
design/lz77_pkg.sv
design/lz77_ctrl.sv
design/lz77_match.sv
design/lz77_token.sv
design/lz77_top.sv
sim/lz77_tb.sv

/* Bender.yml */
package:
  name: lz77_comp

sources:
  - design/lz77_pkg.sv
  - design/lz77_ctrl.sv
  - design/lz77_match.sv
  - design/lz77_token.sv
  - design/lz77_top.sv
  - target: simulation
    files:
      - sim/lz77_tb.sv
